//--- sim.f
+incdir+src
src/gfx_map_pkg.sv
src/gfx_credit_fifo.sv
src/gfx_bank_decode.sv
src/gfx_bank_mapper.sv
src/gfx_rom_addr.sv
src/gfx_rom_issue.sv
src/gfx_map_top.sv
verification/gfx_map_tb.sv

//--- src/gfx_bank_decode.sv
`timescale 1ns/1ns

`include "gfx_map_cfg.svh"

module gfx_bank_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [5:0]              game,
    input  logic                    valid_in,
    input  gfx_map_pkg::fetch_req_t req_in,
    output logic                    valid_out,
    output gfx_map_pkg::fetch_req_t req_out,
    output logic [3:0]              bank      // One-hot, zero when unmapped
);

    import gfx_map_pkg::*;

    logic [3:0] bank_sel;
    logic [3:0] nibble;

    assign nibble = req_in.code[15:12]; // Top code nibble drives the split games

    // Per-game table
    always_comb begin
        bank_sel = 4'b0000;
        case (game)
            `GFX_GAME_FFIGHT: begin
                case (req_in.layer)
                    OBJ:       bank_sel = 4'b0001;
                    SCR1:      bank_sel = 4'b0010;
                    SCR2, SCR3: bank_sel = 4'b0100;
                    default:   bank_sel = 4'b0000;
                endcase
            end
            `GFX_GAME_SF2: begin
                case (req_in.layer)
                    OBJ: begin
                        // Sprites split across two banks
                        if (nibble < 4'(`GFX_SF2_OBJ_SPLIT))
                            bank_sel = 4'b0001;
                        else
                            bank_sel = 4'b0010;
                    end
                    SCR1, SCR2, SCR3: bank_sel = 4'b0100;
                    default:          bank_sel = 4'b0000;
                endcase
            end
            `GFX_GAME_GHOULS: begin
                case (req_in.layer) // One bank per layer
                    OBJ:     bank_sel = 4'b0001;
                    SCR1:    bank_sel = 4'b0010;
                    SCR2:    bank_sel = 4'b0100;
                    SCR3:    bank_sel = 4'b1000;
                    default: bank_sel = 4'b0000;
                endcase
            end
            `GFX_GAME_DINO: begin
                case (req_in.layer)
                    OBJ, SCR1: bank_sel = 4'b0001; // Shared bank
                    SCR2:      bank_sel = 4'b0010;
                    SCR3: begin
                        // Upper SCR3 codes have no ROM behind them
                        if (nibble < 4'(`GFX_DINO_SCR3_LIMIT))
                            bank_sel = 4'b0100;
                    end
                    default:   bank_sel = 4'b0000;
                endcase
            end
            default: bank_sel = 4'b0000; // Unknown game
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_out <= 1'b0;
            bank      <= 4'b0000;
        end else begin
            valid_out <= valid_in;
            if (valid_in)
                bank <= bank_sel;
        end
    end

    // Request travels alongside its bank
    always_ff @(posedge clk) begin
        if (valid_in)
            req_out <= req_in;
    end

endmodule

//--- src/gfx_bank_mapper.sv
`timescale 1ns/1ns

module gfx_bank_mapper (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_in,
    input  gfx_map_pkg::fetch_req_t req_in,
    input  logic [3:0]              bank,
    input  gfx_map_pkg::bank_cfg_t  cfg,
    output logic                    valid_out,
    output gfx_map_pkg::fetch_req_t req_out,
    output logic [3:0]              offset,
    output logic [3:0]              mask,
    output logic                    unmapped
);

    logic [3:0] offset_sel;
    logic [3:0] mask_sel;

    // Nibble pick for the one-hot bank
    always_comb begin
        case (bank)
            4'b0001: {offset_sel, mask_sel} = {cfg.bank_offset[3:0],   cfg.bank_mask[3:0]};
            4'b0010: {offset_sel, mask_sel} = {cfg.bank_offset[7:4],   cfg.bank_mask[7:4]};
            4'b0100: {offset_sel, mask_sel} = {cfg.bank_offset[11:8],  cfg.bank_mask[11:8]};
            4'b1000: {offset_sel, mask_sel} = {cfg.bank_offset[15:12], cfg.bank_mask[15:12]};
            default: {offset_sel, mask_sel} = {4'h0, 4'hf}; // Pass the code nibble through
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            valid_out <= 1'b0;
        else
            valid_out <= valid_in;
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            req_out  <= req_in;
            offset   <= offset_sel;
            mask     <= mask_sel;
            unmapped <= (bank == 4'b0000); // No bank selected
        end
    end

endmodule

//--- src/gfx_credit_fifo.sv
`timescale 1ns/1ns

module gfx_credit_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  T                             din,
    input  logic                         pop,
    output T                             dout,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T mem [DEPTH];                // Payload storage
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          full;
    logic          do_push;
    logic          do_pop;

    // Wrap for depths that are not a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        if (p == AW'(DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == CW'(DEPTH));
    assign do_pop  = pop && !empty;             // Ignore pops on empty
    assign do_push = push && (!full || do_pop); // Full queue still takes a push with a pop
    assign dout    = mem[rd_ptr];               // Head is always visible

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ; // Both or neither keeps the level
            endcase
        end
    end

endmodule

//--- src/gfx_map_cfg.svh
`ifndef GFX_MAP_CFG_SVH
`define GFX_MAP_CFG_SVH

// Intake queue depth
// The host starts with this many credits
`define GFX_IN_DEPTH 8

// Output queue depth toward the ROM side
`define GFX_OUT_DEPTH 8

// Credits held by the issue side out of reset
`define GFX_ROM_CREDITS 4

// Game identifiers seen on the 6-bit game input
`define GFX_GAME_FFIGHT 0
`define GFX_GAME_SF2 1
`define GFX_GAME_GHOULS 2
`define GFX_GAME_DINO 3

// Code nibble limits used by the decode table
`define GFX_SF2_OBJ_SPLIT 8    // OBJ nibbles at or above go to bank 1
`define GFX_DINO_SCR3_LIMIT 12 // SCR3 nibbles from here up are unmapped

`endif

//--- src/gfx_map_pkg.sv
package gfx_map_pkg;

    // Layer engines that fetch graphics
    // Encoding follows the board's A[22:20] field
    typedef enum logic [2:0] {
        OBJ  = 3'd0, // Sprites
        SCR1 = 3'd1,
        SCR2 = 3'd2,
        SCR3 = 3'd3
    } layer_e;

    // Fetch request from a layer engine
    typedef struct packed {
        layer_e      layer;
        logic [15:0] code;  // Tile or sprite code
        logic [3:0]  row;   // Row inside the tile
    } fetch_req_t;

    // Board configuration for the bank mapper
    // One nibble per bank in each field, bank 0 in bits 3:0
    typedef struct packed {
        logic [15:0] bank_offset;
        logic [15:0] bank_mask;
    } bank_cfg_t;

    // Request sent to the graphics ROM
    typedef struct packed {
        logic [19:0] addr;
        layer_e      layer; // Kept for the pixel return path
    } rom_req_t;

endpackage

//--- src/gfx_map_top.sv
`timescale 1ns/1ns

`include "gfx_map_cfg.svh"

module gfx_map_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [5:0]              game,
    input  gfx_map_pkg::bank_cfg_t  cfg,
    input  logic                    req_valid,  // Only while the host holds a credit
    input  gfx_map_pkg::fetch_req_t req,
    output logic                    req_credit,
    output logic                    rom_valid,
    output gfx_map_pkg::rom_req_t   rom_req,
    input  logic                    rom_credit,
    output logic [15:0]             drop_count
);

    import gfx_map_pkg::*;

    fetch_req_t in_head;
    logic       in_empty;
    logic       in_pop;
    rom_req_t   out_req;
    logic       out_push;
    rom_req_t   out_head;
    logic       out_empty;
    logic       out_pop;
    logic [$clog2(`GFX_OUT_DEPTH+1)-1:0] out_count;

    // Every intake pop frees one host slot
    assign req_credit = in_pop;

    // Intake queue, sized to the host credit pool
    gfx_credit_fifo #(
        .T     (fetch_req_t),
        .DEPTH (`GFX_IN_DEPTH)
    ) u_in_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (req_valid),
        .din   (req),
        .pop   (in_pop),
        .dout  (in_head),
        .empty (in_empty),
        .count ()          // Host credits already bound the level
    );

    // Decode, map and address stages
    gfx_rom_addr u_addr (
        .clk        (clk),
        .rst        (rst),
        .game       (game),
        .cfg        (cfg),
        .in_req     (in_head),
        .in_empty   (in_empty),
        .in_pop     (in_pop),
        .out_count  (out_count),
        .out_push   (out_push),
        .out_req    (out_req),
        .drop_count (drop_count)
    );

    gfx_credit_fifo #(
        .T     (rom_req_t),
        .DEPTH (`GFX_OUT_DEPTH)
    ) u_out_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (out_push),
        .din   (out_req),
        .pop   (out_pop),
        .dout  (out_head),
        .empty (out_empty),
        .count (out_count)  // Space accounting upstream
    );

    // ROM side credit gate
    gfx_rom_issue u_issue (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (out_empty),
        .fifo_head  (out_head),
        .fifo_pop   (out_pop),
        .rom_credit (rom_credit),
        .rom_valid  (rom_valid),
        .rom_req    (rom_req)
    );

endmodule

//--- src/gfx_rom_addr.sv
`timescale 1ns/1ns

`include "gfx_map_cfg.svh"

module gfx_rom_addr (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [5:0]                           game,
    input  gfx_map_pkg::bank_cfg_t               cfg,
    input  gfx_map_pkg::fetch_req_t              in_req,    // Intake head
    input  logic                                 in_empty,
    output logic                                 in_pop,
    input  logic [$clog2(`GFX_OUT_DEPTH+1)-1:0]  out_count,
    output logic                                 out_push,
    output gfx_map_pkg::rom_req_t                out_req,
    output logic [15:0]                          drop_count
);

    import gfx_map_pkg::*;

    localparam int CW = $clog2(`GFX_OUT_DEPTH + 1);
    localparam int SW = CW + 1; // Room for queue level plus stages

    logic       dec_valid;
    fetch_req_t dec_req;
    logic [3:0] dec_bank;
    logic       map_valid;
    fetch_req_t map_req;
    logic [3:0] map_offset;
    logic [3:0] map_mask;
    logic       map_unmapped;
    logic [SW-1:0] occupancy;
    logic [3:0] addr_hi;

    // Queue level plus one slot per busy stage
    // Dropped items still hold their slot until they leave
    assign occupancy = SW'(out_count) + SW'(dec_valid) + SW'(map_valid) + SW'(out_push);
    assign in_pop    = !in_empty && (occupancy < SW'(`GFX_OUT_DEPTH));

    gfx_bank_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .game      (game),
        .valid_in  (in_pop),
        .req_in    (in_req),
        .valid_out (dec_valid),
        .req_out   (dec_req),
        .bank      (dec_bank)
    );

    gfx_bank_mapper u_mapper (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (dec_valid),
        .req_in    (dec_req),
        .bank      (dec_bank),
        .cfg       (cfg),
        .valid_out (map_valid),
        .req_out   (map_req),
        .offset    (map_offset),
        .mask      (map_mask),
        .unmapped  (map_unmapped)
    );

    assign addr_hi = (map_req.code[15:12] & map_mask) | map_offset; // Bank select bits

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_push   <= 1'b0;
            drop_count <= '0;
        end else begin
            out_push <= map_valid && !map_unmapped;
            if (map_valid && map_unmapped)
                drop_count <= drop_count + 16'd1; // Wraps silently
        end
    end

    always_ff @(posedge clk) begin
        if (map_valid && !map_unmapped) begin
            out_req.addr  <= {addr_hi, map_req.code[11:0], map_req.row};
            out_req.layer <= map_req.layer;
        end
    end

endmodule

//--- src/gfx_rom_issue.sv
`timescale 1ns/1ns

`include "gfx_map_cfg.svh"

module gfx_rom_issue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fifo_empty,
    input  gfx_map_pkg::rom_req_t fifo_head,
    output logic                  fifo_pop,
    input  logic                  rom_credit, // One credit back per pulse
    output logic                  rom_valid,
    output gfx_map_pkg::rom_req_t rom_req
);

    localparam int CRW = $clog2(`GFX_ROM_CREDITS + 1);

    logic [CRW-1:0] credits;
    logic           have_credit;

    assign have_credit = (credits != '0);
    // Credit is spent at the pop, the send shows up a cycle later
    assign fifo_pop    = !fifo_empty && have_credit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CRW'(`GFX_ROM_CREDITS);
        end else begin
            case ({rom_credit, fifo_pop})
                2'b10:   credits <= credits + 1'b1; // Return only
                2'b01:   credits <= credits - 1'b1; // Send only
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rom_valid <= 1'b0;
        else
            rom_valid <= fifo_pop;
    end

    // Hold the head registered for the ROM side
    always_ff @(posedge clk) begin
        if (fifo_pop)
            rom_req <= fifo_head;
    end

endmodule

//--- verification/gfx_map_tb.sv
`timescale 1ns/1ns

`include "gfx_map_cfg.svh"

module gfx_map_tb;

    import gfx_map_pkg::*;

    localparam int WAIT_LIMIT = 2000; // Cycles allowed per wait loop

    logic        clk = 1'b0;
    logic        rst;
    logic [5:0]  game;
    bank_cfg_t   cfg;
    logic        req_valid;
    fetch_req_t  req;
    logic        req_credit;
    logic        rom_valid;
    rom_req_t    rom_req;
    logic        rom_credit;
    logic [15:0] drop_count;

    logic [31:0] lfsr = 32'h8a32770f;
    rom_req_t    exp_q[$];                     // Expected ROM requests in order
    int          host_credits = `GFX_IN_DEPTH;
    int          pending;                      // Sends the ROM has not credited back
    bit          rom_hold;                     // ROM withholds credits
    bit          give_credit;
    int          sent_count;
    int          credit_pulses;
    int          exp_drops;
    int          rom_sends;
    string       test_name;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;

    gfx_map_top dut (
        .clk        (clk),
        .rst        (rst),
        .game       (game),
        .cfg        (cfg),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rom_valid  (rom_valid),
        .rom_req    (rom_req),
        .rom_credit (rom_credit),
        .drop_count (drop_count)
    );

    always #2 clk = ~clk; // 4 ns period

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        b;
        val = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b)
                lfsr = lfsr ^ 32'h80200003; // x^32 + x^22 + x^2 + x + 1
            val = {val[30:0], b};
        end
        return val;
    endfunction

    function automatic fetch_req_t random_req();
        fetch_req_t  r;
        logic [31:0] bits;
        bits    = take_bits(22);
        r.layer = layer_e'({1'b0, bits[21:20]}); // Only the four real layers
        r.code  = bits[19:4];
        r.row   = bits[3:0];
        return r;
    endfunction

    // Expected ROM request from the game table and the offset/mask rule
    function automatic bit ref_map(input logic [5:0] g, input bank_cfg_t c,
                                   input fetch_req_t r, output rom_req_t e);
        int         b;
        logic [3:0] nib;
        logic [3:0] off;
        logic [3:0] msk;
        nib = r.code[15:12];
        b   = -1; // No bank
        e   = '0;
        case (g)
            `GFX_GAME_FFIGHT: b = (r.layer == OBJ) ? 0 : ((r.layer == SCR1) ? 1 : 2);
            `GFX_GAME_SF2:    b = (r.layer != OBJ) ? 2 : ((nib >= 4'd8) ? 1 : 0);
            `GFX_GAME_GHOULS: b = int'(r.layer); // Bank follows layer
            `GFX_GAME_DINO: begin
                if (r.layer == OBJ || r.layer == SCR1)
                    b = 0;
                else if (r.layer == SCR2)
                    b = 1;
                else if (nib < 4'd12)
                    b = 2;
            end
            default: b = -1;
        endcase
        if (b < 0)
            return 1'b0;
        off     = c.bank_offset[4*b +: 4];
        msk     = c.bank_mask[4*b +: 4];
        e.addr  = {(nib & msk) | off, r.code[11:0], r.row};
        e.layer = r.layer;
        return 1'b1;
    endfunction

    task automatic note_error(input string msg);
        $display("Error in %s: %s", test_name, msg);
        test_errors++;
        total_errors++;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
        test_errors++;
        total_errors++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0)
            $display("Test %s passed", test_name);
        else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic send_req(input fetch_req_t r);
        int       waited;
        rom_req_t e;
        waited = 0;
        while (host_credits == 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (host_credits == 0)
            note_error("host credit never came back");
        else begin
            req       = r;
            req_valid = 1'b1;
            host_credits--;
            sent_count++;
            if (ref_map(game, cfg, r, e))
                exp_q.push_back(e);
            else
                exp_drops++;
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    task automatic send_burst(input int n);
        for (int i = 0; i < n; i++) begin
            send_req(random_req());
            if (take_bits(2) == 32'd0)
                @(negedge clk); // Occasional idle gap
        end
    endtask

    // Wait for all traffic and credits to settle
    task automatic drain();
        int waited;
        waited = 0;
        while (!(exp_q.size() == 0 && host_credits == `GFX_IN_DEPTH && pending == 0)
               && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT)
            note_error("traffic did not drain before the timeout");
        repeat (6) @(negedge clk); // Pipeline depth plus the last credit return
        if (exp_q.size() != 0)
            note_error("expected ROM requests never arrived");
    endtask

    // Host credit pool, never more than the intake depth
    always @(posedge clk) begin
        if (!rst && req_credit === 1'b1) begin
            if (host_credits >= `GFX_IN_DEPTH)
                note_error("req_credit pulsed with no request outstanding");
            host_credits  = host_credits + 1;
            credit_pulses = credit_pulses + 1;
        end
    end

    // Checker, one expected entry per send
    always @(posedge clk) begin : compare_proc
        rom_req_t e;
        if (!rst && rom_valid === 1'b1) begin
            rom_sends++;
            if (exp_q.size() == 0)
                note_error("rom_valid without an expected request");
            else begin
                e = exp_q.pop_front();
                if (rom_req !== e)
                    report_mismatch("rom_req", e, rom_req);
            end
        end
    end

    // ROM model, returns each credit after a random delay
    always @(posedge clk) begin
        if (rom_valid === 1'b1)
            pending = pending + 1;
        give_credit = 1'b0;
        if (pending > 0 && !rom_hold && take_bits(1) == 32'd1) begin
            give_credit = 1'b1;
            pending     = pending - 1;
        end
    end

    always @(negedge clk)
        rom_credit = give_credit;

    initial begin : main_seq
        int         base;
        fetch_req_t r;
        string      names[4];
        names      = '{"game_ffight", "game_sf2", "game_ghouls", "game_dino"};
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        game       = `GFX_GAME_FFIGHT;
        cfg        = '0;
        rom_credit = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset");
        if (req_credit !== 1'b0)
            note_error("req_credit high after reset");
        if (rom_valid !== 1'b0)
            note_error("rom_valid high after reset");
        if (drop_count !== 16'd0)
            report_mismatch("drop_count", 0, drop_count);
        repeat (10) @(negedge clk); // Checker flags any stray send
        end_test();

        cfg = take_bits(32);
        for (int g = 0; g < 4; g++) begin
            start_test(names[g]);
            game = 6'(g);
            send_burst(24);
            drain();
            end_test();
        end

        start_test("unmapped");
        game = `GFX_GAME_DINO;
        for (int i = 0; i < 12; i++) begin
            r              = random_req();
            r.layer        = SCR3;
            r.code[15:14]  = 2'b11; // Nibble 12 and up
            send_req(r);
        end
        drain();
        game = 6'h2a; // Not a known game
        send_burst(8);
        drain();
        if (drop_count !== 16'(exp_drops))
            report_mismatch("drop_count", exp_drops, drop_count);
        end_test();

        start_test("config_sweep");
        for (int k = 0; k < 6; k++) begin
            cfg  = take_bits(32);
            game = k[0] ? `GFX_GAME_SF2 : `GFX_GAME_GHOULS;
            send_burst(16);
            drain();
        end
        end_test();

        start_test("back_pressure");
        rom_hold = 1'b1;
        game     = `GFX_GAME_GHOULS;
        base     = rom_sends;
        for (int i = 0; i < 80; i++) begin
            if (host_credits > 0)
                send_req(random_req());
            else
                @(negedge clk);
        end
        if (rom_sends - base > `GFX_ROM_CREDITS)
            report_mismatch("sends while credits held", `GFX_ROM_CREDITS, rom_sends - base);
        if (host_credits != 0)
            note_error("host credits did not run out under back-pressure");
        rom_hold = 1'b0;
        drain();
        end_test();

        start_test("credit_accounting");
        game = `GFX_GAME_SF2;
        send_burst(16);
        drain();
        if (credit_pulses != sent_count)
            report_mismatch("req_credit pulses", sent_count, credit_pulses);
        if (host_credits != `GFX_IN_DEPTH)
            report_mismatch("host credits", `GFX_IN_DEPTH, host_credits);
        end_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
